//--- tb/clock_phase_testdata.txt
# name channel action code count dir ; count = expected steps, dir 1 = increment
# lock records: code = reset_on_lock_loss, count = expected global_reset, dir = lock_lost_err
lock_refire          0 lock       1    1 0
lock_hold            0 lock       0    0 1
code0_from_zero      0 fire       0    0 1
code1_from_zero      0 fire       1    5 1
code128_from_zero    1 fire     128  700 1
code255_from_zero    2 fire     255 1395 1
step_down            2 fire     128  695 0
refire_same          2 fire     128    0 1
reset_ch2            2 chreset    0    0 1
refire_after_reset   2 fire     128  700 1
all_channels         0 fire      64  345 1
all_channels         1 fire      32  525 0
all_channels         2 fire     200  394 1
all_channels         3 fire       7   38 1
lock_wait            3 droplock 100  509 1
half_round           3 fire      16  459 0
reset_ch0            0 chreset    0    0 1
code255_after_reset  0 fire     255 1395 1
lock_refire_clear    0 lock       1    1 0
after_global_reset   1 fire       1    5 1

//--- clock_phase_ctrl.f
verilog/clock_phase_pkg.sv
verilog/phase_step_rom.sv
verilog/phase_stepper.sv
verilog/lock_reset_gen.sv
verilog/clock_phase_ctrl.sv
tb/clock_phase_ctrl_asserts.sv
tb/clock_phase_ctrl_tb.sv

//--- Makefile
# Verilator simulation of the clock phase controller

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f clock_phase_ctrl.f \
		--top-module clock_phase_ctrl_tb -Mdir obj_dir -o sim_clock_phase_ctrl
	./obj_dir/sim_clock_phase_ctrl > $(LOG) 2>&1 || true
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

//--- tb/clock_phase_ctrl_tb.sv
`timescale 1ns/1ns

module clock_phase_ctrl_tb
	import clock_phase_pkg::*;
();

	localparam int ch_w              = $clog2(num_shifters);        // Channel index width
	localparam int hold_cycles       = 20;                          // Unlocked wait in droplock
	localparam int cycles_per_record = steps_per_cycle * 13 + 20;   // Worst-case run length

	logic           clock = 1'b0;
	logic           reset;
	logic           main_lock;
	logic           reset_on_lock_loss;
	logic           global_reset;
	logic           lock_lost_err;
	shifter_mask_t  dps_fire;
	shifter_mask_t  dps_reset;
	shifter_mask_t  dps_lock;
	shifter_mask_t  dps_psdone;                                     // From clock-tile models
	shifter_mask_t  dps_psen;
	shifter_mask_t  dps_psincdec;
	shifter_mask_t  dps_busy;
	phase_code_t    dps_phase [num_shifters];
	stepper_state_t dps_sm_vec [num_shifters];

	step_t          inc_count [num_shifters];                       // Running psen tallies that may wrap
	step_t          dec_count [num_shifters];

	string          rec_name [$];                                   // Test records from data file
	string          rec_action [$];
	int             rec_channel [$];
	int             rec_code [$];
	int             rec_count [$];
	int             rec_dir [$];

	int             value_errors = 0;
	int             other_errors = 0;
	int             cycle_count  = 0;
	int             cycle_limit  = 0;                               // Set once records are known

	always #20 clock = ~clock;                                      // 40 ns period

	always @(posedge clock) cycle_count <= cycle_count + 1;

	clock_phase_ctrl i_clock_phase_ctrl (
		.clock              (clock),
		.reset              (reset),
		.main_lock          (main_lock),
		.reset_on_lock_loss (reset_on_lock_loss),
		.global_reset       (global_reset),
		.lock_lost_err      (lock_lost_err),
		.dps_fire           (dps_fire),
		.dps_reset          (dps_reset),
		.dps_phase          (dps_phase),
		.dps_busy           (dps_busy),
		.dps_sm_vec         (dps_sm_vec),
		.dps_lock           (dps_lock),
		.dps_psen           (dps_psen),
		.dps_psincdec       (dps_psincdec),
		.dps_psdone         (dps_psdone)
	);

// ------------------------------------------------------------
// Clock-tile models, one per channel
// ------------------------------------------------------------
	for (genvar c = 0; c < num_shifters; c++) begin : g_tile
		logic  done_bit;                                            // psdone for this tile
		logic  step_seen;
		int    wait_left;                                           // Cycles until psdone
		step_t inc_total;
		step_t dec_total;

		assign dps_psdone[c] = done_bit;
		assign inc_count[c]  = inc_total;
		assign dec_count[c]  = dec_total;

		initial begin
			done_bit  = 1'b0;
			step_seen = 1'b0;
			wait_left = 0;
			inc_total = '0;
			dec_total = '0;
			forever begin
				@(posedge clock);
				#1;                                                 // Sample psen after the edge
				step_seen = dps_psen[c];
				if (step_seen && dps_psincdec[c]) begin
					inc_total = inc_total + step_t'(1);
				end else if (step_seen) begin
					dec_total = dec_total + step_t'(1);
				end
				#1;                                                 // Drive point
				done_bit = 1'b0;
				if (wait_left > 0) begin
					wait_left = wait_left - 1;
					if (wait_left == 0) begin
						done_bit = 1'b1;                            // One-cycle pulse
					end
				end
				if (step_seen) begin
					wait_left = int'($urandom % 32'd12) + 1;        // 1 to 12 cycles
				end
			end
		end
	end

// ------------------------------------------------------------
// Compare tasks
// ------------------------------------------------------------
	task automatic check_steps(input string test, input string what,
			input step_t expected, input step_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("ERROR %s %s: expected %0d, actual %0d", test, what, expected, actual);
		end
	endtask

	task automatic check_bit(input string test, input string what,
			input logic expected, input logic actual);
		if (actual !== expected) begin
			value_errors++;
			$display("ERROR %s %s: expected %b, actual %b", test, what, expected, actual);
		end
	endtask

	task automatic check_state(input string test, input string what,
			input stepper_state_t expected, input stepper_state_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("ERROR %s %s: expected %s, actual %s", test, what,
				expected.name(), actual.name());
		end
	endtask

// ------------------------------------------------------------
// Test records
// ------------------------------------------------------------
	task automatic load_records();
		int    fd;
		int    fields;
		string line;
		string name;
		string action;
		int    channel;
		int    code;
		int    count;
		int    dir;
		fd = $fopen("tb/clock_phase_testdata.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("Could not open the test data file tb/clock_phase_testdata.txt");
		end else begin
			while (!$feof(fd)) begin
				line   = "";
				fields = $fgets(line, fd);
				fields = $sscanf(line, "%s %d %s %d %d %d", name, channel, action, code, count, dir);
				if (fields == 6 && (channel < 0 || channel >= num_shifters)) begin
					other_errors++;                                 // Record with a bad channel is skipped
					$display("Record %s names channel %0d, which does not exist", name, channel);
				end else if (fields == 6) begin
					rec_name.push_back(name);
					rec_action.push_back(action);
					rec_channel.push_back(channel);
					rec_code.push_back(code);
					rec_count.push_back(count);
					rec_dir.push_back(dir);
				end
			end
			$fclose(fd);
		end
	endtask

	// Global reset held until the first main lock and released one cycle after it
	task automatic startup_sequence();
		repeat (10) @(posedge clock);
		#2;
		reset = 1'b0;
		repeat (4) begin
			@(negedge clock);
			check_bit("startup", "global_reset before lock", 1'b1, global_reset);
		end
		@(posedge clock);
		#2;
		main_lock = 1'b1;
		@(negedge clock);
		check_bit("startup", "global_reset in lock cycle", 1'b1, global_reset);
		@(posedge clock);
		@(negedge clock);
		check_bit("startup", "global_reset after lock", 1'b0, global_reset);
	endtask

	// Lock records carry reset_on_lock_loss in the code column
	// Their count and dir columns hold the expected reset and error
	task automatic lock_loss_test(input int k);
		@(posedge clock);
		#2;
		reset_on_lock_loss = (rec_code[k] != 0);
		main_lock          = 1'b0;
		repeat (4) begin
			@(posedge clock);
			@(negedge clock);
			check_bit(rec_name[k], "global_reset while unlocked", rec_count[k] != 0, global_reset);
			check_bit(rec_name[k], "lock_lost_err while unlocked", rec_dir[k] != 0, lock_lost_err);
		end
		@(posedge clock);
		#2;
		main_lock = 1'b1;
		@(posedge clock);
		@(negedge clock);
		check_bit(rec_name[k], "global_reset after relock", 1'b0, global_reset);
		check_bit(rec_name[k], "lock_lost_err after relock", 1'b0, lock_lost_err);
	endtask

	task automatic channel_reset_pulse(input int k);
		logic [ch_w-1:0] ch;
		ch = ch_w'(rec_channel[k]);
		@(posedge clock);
		#2;
		dps_reset[ch] = 1'b1;                                       // One-cycle tile reset
		@(posedge clock);
		#2;
		dps_reset[ch] = 1'b0;
		@(negedge clock);
		check_bit(rec_name[k], "busy after channel reset", 1'b0, dps_busy[ch]);
		check_state(rec_name[k], "state after channel reset", ps_idle, dps_sm_vec[ch]);
	endtask

	// Fires records first to last-1 together with tile locks optionally held low
	task automatic fire_group(input int first, input int last, input logic hold);
		logic [ch_w-1:0] ch;
		shifter_mask_t   group;
		step_t           start_inc [num_shifters];
		step_t           start_dec [num_shifters];
		step_t           exp_inc;
		step_t           exp_dec;
		int              cycles;
		logic            done;
		group = '0;
		@(posedge clock);
		#2;
		for (int k = first; k < last; k++) begin
			ch            = ch_w'(rec_channel[k]);
			group[ch]     = 1'b1;
			dps_phase[ch] = phase_code_t'(rec_code[k]);
			start_inc[ch] = inc_count[ch];                          // Snapshot tallies
			start_dec[ch] = dec_count[ch];
		end
		if (hold) begin
			dps_lock = dps_lock & ~group;                           // Tiles report no lock
		end
		dps_fire = dps_fire | group;
		if (hold) begin
			repeat (hold_cycles) begin
				@(posedge clock);
				@(negedge clock);
			end
			for (int k = first; k < last; k++) begin
				ch = ch_w'(rec_channel[k]);
				check_steps(rec_name[k], "steps while unlocked", '0,
					(inc_count[ch] - start_inc[ch]) + (dec_count[ch] - start_dec[ch]));
				check_bit(rec_name[k], "busy while unlocked", 1'b1, dps_busy[ch]);
				check_state(rec_name[k], "state while unlocked", ps_wait_lock, dps_sm_vec[ch]);
			end
			@(posedge clock);
			#2;
			dps_lock = dps_lock | group;                            // Locks return
		end
		cycles = 0;
		done   = 1'b0;
		while (!done) begin
			@(posedge clock);
			cycles++;
			@(negedge clock);
			if (cycles == 1) begin
				for (int k = first; k < last; k++) begin
					ch = ch_w'(rec_channel[k]);
					check_bit(rec_name[k], "busy after fire", 1'b1, dps_busy[ch]);
				end
			end
			done = ((dps_busy & group) == '0);                      // All runs ended
		end
		for (int k = first; k < last; k++) begin
			ch      = ch_w'(rec_channel[k]);
			exp_inc = (rec_dir[k] != 0) ? step_t'(rec_count[k]) : '0;
			exp_dec = (rec_dir[k] != 0) ? '0 : step_t'(rec_count[k]);
			check_steps(rec_name[k], "increments", exp_inc, inc_count[ch] - start_inc[ch]);
			check_steps(rec_name[k], "decrements", exp_dec, dec_count[ch] - start_dec[ch]);
			check_state(rec_name[k], "state after run", ps_idle, dps_sm_vec[ch]);
			if (last - first == 1 && rec_count[k] == 0 && !hold) begin
				check_steps(rec_name[k], "cycles to busy low", step_t'(3), step_t'(cycles));
			end
		end
		@(posedge clock);
		#2;
		dps_fire = dps_fire & ~group;
	endtask

// ------------------------------------------------------------
// Main sequence
// ------------------------------------------------------------
	initial begin
		int first;
		int next;
		reset              = 1'b1;
		main_lock          = 1'b0;
		reset_on_lock_loss = 1'b1;
		dps_fire           = '0;
		dps_reset          = '0;
		dps_lock           = '1;
		dps_phase          = '{default: '0};
		void'($urandom(9125));                                      // Seeds the tile delays
		load_records();
		cycle_limit = rec_name.size() * cycles_per_record;
		if (rec_name.size() == 0) begin
			other_errors++;
			$display("No test records were read, nothing was tested");
		end else begin
			startup_sequence();
			first = 0;
			while (first < rec_name.size()) begin
				next = first + 1;
				if (rec_action[first] == "fire") begin
					// Same name on consecutive fire records means one simultaneous launch
					while (next < rec_name.size() && rec_action[next] == "fire"
							&& rec_name[next] == rec_name[first]) begin
						next++;
					end
					fire_group(first, next, 1'b0);
				end else if (rec_action[first] == "droplock") begin
					fire_group(first, next, 1'b1);
				end else if (rec_action[first] == "lock") begin
					lock_loss_test(first);
				end else if (rec_action[first] == "chreset") begin
					channel_reset_pulse(first);
				end else begin
					other_errors++;
					$display("Record %s has an unknown action %s", rec_name[first], rec_action[first]);
				end
				first = next;
			end
		end
		$display("Done: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// Watchdog on the whole run
	initial begin
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit) @(posedge clock);
		other_errors++;
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Done: %0d value errors, %0d other errors", value_errors, other_errors);
		$display("TEST FAIL");
		$finish;
	end

endmodule

//--- tb/clock_phase_ctrl_asserts.sv
`timescale 1ns/1ns

module clock_phase_ctrl_asserts
	import clock_phase_pkg::*;
(
	input logic          clock,
	input logic          reset,
	input logic          global_reset,
	input logic          lock_lost_err,
	input shifter_mask_t dps_reset,
	input shifter_mask_t dps_busy,
	input shifter_mask_t dps_psen,
	input shifter_mask_t dps_psdone
);

// ------------------------------------------------------------
// Outstanding step per channel
// ------------------------------------------------------------
	shifter_mask_t step_pending;                      // psen seen and psdone not yet

	always_ff @(posedge clock) begin
		if (reset || global_reset) begin
			step_pending <= '0;
		end else begin
			step_pending <= (step_pending | dps_psen) & ~(dps_psdone | dps_reset);
		end
	end

	for (genvar i = 0; i < num_shifters; i++) begin : g_chan
		// Busy must already be up in the cycle before a step enable starts
		a_psen_busy: assert property (@(posedge clock) disable iff (reset)
			$rose(dps_psen[i]) |-> $past(dps_busy[i]))
			else $error("Channel %0d step enable while not busy", i);

		a_one_step: assert property (@(posedge clock) disable iff (reset || global_reset || dps_reset[i])
			dps_psen[i] |-> !step_pending[i])
			else $error("Channel %0d second step enable before step done", i);
	end

	// Registers cleared the cycle after reset
	a_reset_idle: assert property (@(posedge clock)
		reset |=> (dps_busy == '0 && dps_psen == '0 && !lock_lost_err))
		else $error("Outputs not idle after reset");

endmodule

bind clock_phase_ctrl clock_phase_ctrl_asserts i_clock_phase_ctrl_asserts (
	.clock         (clock),
	.reset         (reset),
	.global_reset  (global_reset),
	.lock_lost_err (lock_lost_err),
	.dps_reset     (dps_reset),
	.dps_busy      (dps_busy),
	.dps_psen      (dps_psen),
	.dps_psdone    (dps_psdone)
);

//--- verilog/clock_phase_ctrl.sv
`timescale 1ns/1ns

module clock_phase_ctrl
	import clock_phase_pkg::*;
(
	input  logic           clock,                    // Main clock
	input  logic           reset,                    // Synchronous reset

	// Main lock and global reset
	input  logic           main_lock,                // Main clock tile locked
	input  logic           reset_on_lock_loss,       // Re-fire global reset on lock loss
	output logic           global_reset,             // Held until first main lock
	output logic           lock_lost_err,            // Main lock lost while running

	// Control bus, one bit or entry per channel
	input  shifter_mask_t  dps_fire,                 // Set new phase
	input  shifter_mask_t  dps_reset,                // Reset current phase
	input  phase_code_t    dps_phase [num_shifters], // Phase code to set
	output shifter_mask_t  dps_busy,                 // Run in progress
	output stepper_state_t dps_sm_vec [num_shifters], // Machine state

	// Clock tile step ports
	input  shifter_mask_t  dps_lock,                 // Tile locked
	output shifter_mask_t  dps_psen,                 // Step enable
	output shifter_mask_t  dps_psincdec,             // Step direction
	input  shifter_mask_t  dps_psdone                // Step done
);

// ------------------------------------------------------------
// Global reset from main lock
// ------------------------------------------------------------
	lock_reset_gen i_lock_reset_gen (
		.clock              (clock),
		.reset              (reset),
		.main_lock          (main_lock),
		.reset_on_lock_loss (reset_on_lock_loss),
		.global_reset       (global_reset),
		.lock_lost_err      (lock_lost_err)
	);

// ------------------------------------------------------------
// Phase shifter channels
// ------------------------------------------------------------
	step_t dps_target [num_shifters];                 // ROM to stepper, combinational

	for (genvar i = 0; i < num_shifters; i++) begin : g_dps
		// 256 codes per cycle mapped onto 1400 fine steps
		phase_step_rom i_phase_step_rom (
			.code   (dps_phase[i]),
			.target (dps_target[i])
		);

		phase_stepper i_phase_stepper (
			.clock         (clock),
			.reset         (reset),
			.global_reset  (global_reset),
			.main_lock     (main_lock),
			.lock          (dps_lock[i]),
			.fire          (dps_fire[i]),
			.channel_reset (dps_reset[i]),        // Tile reset zeroes tracked phase
			.target        (dps_target[i]),
			.psdone        (dps_psdone[i]),
			.psen          (dps_psen[i]),
			.psincdec      (dps_psincdec[i]),
			.busy          (dps_busy[i]),
			.state         (dps_sm_vec[i])
		);
	end

endmodule

//--- verilog/lock_reset_gen.sv
`timescale 1ns/1ns

module lock_reset_gen (
	input  logic clock,                              // Main clock
	input  logic reset,                              // Synchronous reset
	input  logic main_lock,                          // Main clock tile locked
	input  logic reset_on_lock_loss,                 // Re-fire global reset on lock loss
	output logic global_reset,                       // Held until first lock
	output logic lock_lost_err                       // Lock gone while running
);

// ------------------------------------------------------------
// First lock
// ------------------------------------------------------------
	logic startup_done;                               // Set once main lock seen
	logic first_lock;                                 // Lock now or seen before

	assign first_lock = main_lock || startup_done;

	always_ff @(posedge clock) begin
		if (reset) begin
			startup_done <= 1'b0;
			global_reset <= 1'b1;                     // Held high out of reset
		end else begin
			startup_done <= first_lock;               // Sticks after first lock
			// Follows lock one cycle late, re-fires on loss when enabled
			global_reset <= !first_lock || (!main_lock && reset_on_lock_loss);
		end
	end

// ------------------------------------------------------------
// Lock loss flag
// ------------------------------------------------------------
	// Only meaningful once released, otherwise the reset already covers it
	assign lock_lost_err = !global_reset && !main_lock;

endmodule

//--- verilog/phase_stepper.sv
`timescale 1ns/1ns

module phase_stepper
	import clock_phase_pkg::*;
(
	input  logic           clock,                    // Main clock
	input  logic           reset,                    // Synchronous reset
	input  logic           global_reset,             // From lock reset generator

	input  logic           main_lock,                // Main clock tile locked
	input  logic           lock,                     // This channel's tile locked

	input  logic           fire,                     // Level, run starts on rising edge
	input  logic           channel_reset,            // Tile reset, zeroes its phase
	input  step_t          target,                   // Fine step target from ROM

	input  logic           psdone,                   // Tile finished a step
	output logic           psen,                     // One-cycle step enable
	output logic           psincdec,                 // 1 = increment
	output logic           busy,                     // Run in progress
	output stepper_state_t state                     // Machine state for status
);

// ------------------------------------------------------------
// Fire edge
// ------------------------------------------------------------
	logic fire_ff;                                    // Fire delayed one cycle
	logic fire_edge;                                  // Rising edge of fire

	always_ff @(posedge clock) begin
		if (reset) begin
			fire_ff <= 1'b0;
		end else begin
			fire_ff <= fire;                          // Keeps tracking during channel reset
		end
	end

	assign fire_edge = fire && !fire_ff;

// ------------------------------------------------------------
// Position tracking
// ------------------------------------------------------------
	logic  clear;                                     // Any source of reset
	logic  locks_ok;                                  // Stepping allowed
	logic  at_target;                                 // Nothing left to do
	logic  incdec;                                    // Direction of current step
	step_t position;                                  // Tracked tile phase
	step_t position_next;                             // Position after current step

	// Tile reset zeroes its phase, so the tracked copy follows
	assign clear    = reset || global_reset || channel_reset;
	assign locks_ok = main_lock && lock;

	assign at_target     = (target == position);
	assign position_next = incdec ? position + step_t'(1) : position - step_t'(1);

// ------------------------------------------------------------
// Stepper FSM
// ------------------------------------------------------------
	stepper_state_t state_r;                          // Current state

	always_ff @(posedge clock) begin
		if (clear) begin
			state_r  <= ps_idle;
			position <= '0;                           // Back to zero phase
			incdec   <= 1'b0;
		end else begin
			unique case (state_r)
				ps_idle: begin
					if (fire_edge) begin
						state_r <= ps_wait_lock;      // Busy from next cycle
					end
				end

				ps_wait_lock: begin
					if (locks_ok) begin
						state_r <= ps_compare;        // Only back-pressure point
					end
				end

				ps_compare: begin
					if (at_target) begin
						state_r <= ps_idle;           // Zero-step run ends here
					end else begin
						incdec  <= (target > position); // Up if target is ahead
						state_r <= ps_step;
					end
				end

				ps_step: begin
					state_r <= ps_wait_done;          // psen lasts exactly this cycle
				end

				ps_wait_done: begin
					if (psdone) begin
						position <= position_next;    // Step completed by tile
						// Finish straight away so busy drops right after psdone
						if (position_next == target) begin
							state_r <= ps_idle;
						end else begin
							state_r <= ps_wait_lock;
						end
					end
				end

				default: begin
					state_r <= ps_idle;               // Unused encodings recover
				end
			endcase
		end
	end

// ------------------------------------------------------------
// Outputs
// ------------------------------------------------------------
	assign psen     = (state_r == ps_step);           // One pulse per step
	assign psincdec = incdec;                         // Stable across psen
	assign busy     = (state_r != ps_idle);           // High from cycle after fire edge
	assign state    = state_r;

endmodule

//--- verilog/phase_step_rom.sv
`timescale 1ns/1ns

module phase_step_rom
	import clock_phase_pkg::*;
(
	input  phase_code_t code,                        // Phase code 0-255
	output step_t       target                       // Fine step target 0-1395
);

// ------------------------------------------------------------
// Table of fine-step targets, one per phase code
// ------------------------------------------------------------
	typedef step_t [phase_codes-1:0] step_table_t;

	// Half-up rounding of code*1400/256 done in integers
	// Adding half the divisor before the divide equals adding 0.5 then flooring
	function automatic step_table_t fill_table();
		step_table_t table_out;
		int          product;
		table_out = '0;
		for (int i = 0; i < phase_codes; i++) begin
			product      = i * steps_per_cycle;                       // Up to 357000
			table_out[i] = step_t'((product + phase_codes / 2) / phase_codes);
		end
		return table_out;
	endfunction

	localparam step_table_t step_table = fill_table();   // Built at elaboration

// ------------------------------------------------------------
// Lookup
// ------------------------------------------------------------
	// Examples: 0->0, 1->5, 128->700, 255->1395
	assign target = step_table[code];                 // Pure combinational read

endmodule

//--- verilog/clock_phase_pkg.sv
package clock_phase_pkg;

// ------------------------------------------------------------
// Sizes
// ------------------------------------------------------------
	localparam int num_shifters    = 4;              // Phase shifter channels
	localparam int phase_codes     = 256;            // Control bus phase codes per clock cycle
	localparam int steps_per_cycle = 1400;           // Fine steps spanning one clock cycle

	localparam int phase_code_w    = $clog2(phase_codes);     // 8 bits
	localparam int step_w          = $clog2(steps_per_cycle); // 11 bits

// ------------------------------------------------------------
// Vector types
// ------------------------------------------------------------
	typedef logic [phase_code_w-1:0] phase_code_t;   // Phase code from control bus
	typedef logic [step_w-1:0]       step_t;         // Fine step position or target, 0-1399
	typedef logic [num_shifters-1:0] shifter_mask_t; // One bit per channel

// ------------------------------------------------------------
// Stepper machine
// ------------------------------------------------------------
	// Encoding is reported on the control bus as the state vector
	typedef enum logic [2:0] {
		ps_idle      = 3'd0,                          // Waiting for fire
		ps_wait_lock = 3'd1,                          // Holding until both locks are up
		ps_compare   = 3'd2,                          // Pick direction or finish
		ps_step      = 3'd3,                          // Single psen cycle
		ps_wait_done = 3'd4                           // Waiting for tile psdone
	} stepper_state_t;

endpackage
